// File: tb.f
+incdir+include
verilog/gps_pkg.sv
verilog/baseband_if.sv
verilog/delay_line.sv
verilog/carrier_dds.sv
verilog/carrier_lut.sv
verilog/track_accumulator.sv
verilog/subchannel.sv
verilog/ca_code_gen.sv
verilog/correlator_channel.sv
tb/correlator_assert.sv
tb/tb_correlator.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_correlator \
   -o sim_correlator > build.log 2>&1 &&
./obj_dir/sim_correlator +verilator+error+limit+1000 > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

// File: tb/tb_correlator.sv
`timescale 1ns/1ps

module tb_correlator
   import gps_pkg::*;
();

   localparam int unsigned SEED = 32'h9387;
   localparam int FEED_LEN = 64;
   localparam int GAP_FEED_LEN = 40;
   localparam int PRN_FEED_LEN = 128;
   // Cycles allowed from the last strobe to the completion pulse
   localparam int DRAIN_LIMIT = 8;
   localparam int FEED_CYCLES = FEED_LEN + DRAIN_LIMIT + 3;
   localparam int TEST_CYCLES = 30 + 4 * FEED_CYCLES + 4 * GAP_FEED_LEN + DRAIN_LIMIT + 3
                              + 2 * (PRN_FEED_LEN + DRAIN_LIMIT + 3);
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
   // Peak of a signed carrier value
   localparam int CARRIER_PEAK = (1 << (CARRIER_LUT_WIDTH - 1)) - 1;
   localparam real TWO_PI = 6.283185307179586;
   localparam logic [CODE_ACC_WIDTH-1:0] HALF_RATE = 32'h8000_0000;
   localparam logic [CODE_ACC_WIDTH-1:0] QUARTER_RATE = 32'h4000_0000;

   logic                      clk;
   logic                      rst_n_i;
   logic                      clear_i;
   logic                      sample_valid_i;
   logic                      feed_complete_i;
   sample_t                   sample_i;
   doppler_t                  doppler_i;
   logic [CODE_ACC_WIDTH-1:0] code_rate_i;
   logic [PRN_WIDTH-1:0]      prn_i;
   acc_t                      accumulator_i_o;
   acc_t                      accumulator_q_o;
   logic                      accumulator_updating_o;
   logic                      accumulation_complete_o;

   // Strobe history, bit 0 is the previous cycle
   logic [7:0] strobe_hist;
   logic [7:0] last_hist;
   int         error_count;
   int         check_count;
   int         cycle_count;
   sample_t    stim [PRN_FEED_LEN];
   sample_t    base_samples [FEED_LEN];

   // Reference model state
   logic [CARRIER_ACC_WIDTH-1:0] model_carrier_phase;
   logic [CODE_ACC_WIDTH-1:0]    model_code_phase;
   logic [10:1]                  model_g1;
   logic [10:1]                  model_g2;
   acc_t                         model_acc_i;
   acc_t                         model_acc_q;

   correlator_channel u_dut (
      .clk                     (clk),
      .rst_n_i                 (rst_n_i),
      .clear_i                 (clear_i),
      .sample_valid_i          (sample_valid_i),
      .feed_complete_i         (feed_complete_i),
      .sample_i                (sample_i),
      .doppler_i               (doppler_i),
      .code_rate_i             (code_rate_i),
      .prn_i                   (prn_i),
      .accumulator_i_o         (accumulator_i_o),
      .accumulator_q_o         (accumulator_q_o),
      .accumulator_updating_o  (accumulator_updating_o),
      .accumulation_complete_o (accumulation_complete_o)
   );

   bind correlator_channel correlator_assert u_assert (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .clear_i         (clear_i),
      .sample_valid_i  (sample_valid_i),
      .feed_complete_i (feed_complete_i),
      .updating_i      (accumulator_updating_o),
      .complete_i      (accumulation_complete_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog sized from the test lengths
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run went past %0d clock cycles without finishing", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_acc(input acc_t got, input acc_t exp, input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string msg);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, msg, got, exp);
      end
   endtask

   // One cycle of stimulus, flags checked against the strobe history first
   task automatic drive_cycle(input logic valid, input logic last, input sample_t s,
                              input logic clr);
      @(negedge clk);
      check_flag(accumulator_updating_o, strobe_hist[3], "accumulator_updating_o");
      check_flag(accumulation_complete_o, last_hist[4], "accumulation_complete_o");
      strobe_hist = {strobe_hist[6:0], valid};
      last_hist = {last_hist[6:0], valid && last};
      sample_valid_i = valid;
      feed_complete_i = valid && last;
      sample_i = s;
      clear_i = clr;
   endtask

   // Rounded carrier value from the ideal waveform
   function automatic int carrier_value(input real wave);
      real scaled;
      scaled = CARRIER_PEAK * wave;
      if (scaled >= 0.0) begin
         return $rtoi(scaled + 0.5);
      end
      return -$rtoi(0.5 - scaled);
   endfunction

   function automatic void model_reset();
      model_carrier_phase = '0;
      model_code_phase = '0;
      model_g1 = '1;
      model_g2 = '1;
      model_acc_i = '0;
      model_acc_q = '0;
   endfunction

   // One strobe through the reference model
   function automatic void model_sample(input sample_t s, input doppler_t dop,
                                        input logic [CODE_ACC_WIDTH-1:0] rate, input int prn);
      int                      idx;
      int                      cos_v;
      int                      sin_v;
      int                      prod_i;
      int                      prod_q;
      int                      dop_ext;
      real                     angle;
      logic                    chip;
      logic [CODE_ACC_WIDTH:0] code_sum;
      // Carrier point from the phase before this strobe's step
      idx = model_carrier_phase[CARRIER_ACC_WIDTH-1 -: CARRIER_INDEX_WIDTH];
      angle = TWO_PI * idx / real'(1 << CARRIER_INDEX_WIDTH);
      cos_v = carrier_value($cos(angle));
      sin_v = carrier_value($sin(angle));
      // High-side mixing flips the quadrature arm
      if (MIXING_SIGN) begin
         sin_v = -sin_v;
      end
      // Gold code chip current at the strobe
      chip = model_g1[10] ^ model_g2[G2_TAPS[prn-1][0]] ^ model_g2[G2_TAPS[prn-1][1]];
      prod_i = int'(s) * cos_v;
      prod_q = int'(s) * sin_v;
      if (chip) begin
         prod_i = -prod_i;
         prod_q = -prod_q;
      end
      model_acc_i = model_acc_i + acc_t'(prod_i);
      model_acc_q = model_acc_q + acc_t'(prod_q);
      // NCO carry advances both LFSRs one chip
      code_sum = {1'b0, model_code_phase} + rate;
      model_code_phase = code_sum[CODE_ACC_WIDTH-1:0];
      if (code_sum[CODE_ACC_WIDTH]) begin
         model_g1 = {model_g1[9:1], model_g1[3] ^ model_g1[10]};
         model_g2 = {model_g2[9:1], model_g2[2] ^ model_g2[3] ^ model_g2[6]
                     ^ model_g2[8] ^ model_g2[9] ^ model_g2[10]};
      end
      dop_ext = dop;
      model_carrier_phase = model_carrier_phase + F_IF_INC + dop_ext;
   endfunction

   function automatic void fill_random(input int n);
      for (int k = 0; k < n; k++) begin
         stim[k] = sample_t'($urandom_range(7, 0));
      end
   endfunction

   // Completion pulse ends a feed, then the sums are compared
   task automatic wait_complete();
      int waited;
      waited = 0;
      do begin
         drive_cycle(1'b0, 1'b0, '0, 1'b0);
         waited++;
      end while (!accumulation_complete_o && waited < DRAIN_LIMIT);
      if (!accumulation_complete_o) begin
         error_count++;
         $display("accumulation_complete_o never pulsed after the last strobe (time %0t)", $time);
      end
      check_acc(accumulator_i_o, model_acc_i, "I accumulator");
      check_acc(accumulator_q_o, model_acc_q, "Q accumulator");
   endtask

   // Feed of n samples from stim, gaps of up to max_gap idle cycles
   task automatic run_feed(input int n, input doppler_t dop,
                           input logic [CODE_ACC_WIDTH-1:0] rate, input int prn, input int max_gap);
      int gap;
      doppler_i = dop;
      code_rate_i = rate;
      prn_i = PRN_WIDTH'(prn);
      for (int k = 0; k < n; k++) begin
         gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
         repeat (gap) drive_cycle(1'b0, 1'b0, '0, 1'b0);
         drive_cycle(1'b1, k == n - 1, stim[k], 1'b0);
         model_sample(stim[k], dop, rate, prn);
      end
      wait_complete();
   endtask

   // Idle spacing, one clear pulse, then the sums must read zero
   task automatic clear_channel();
      drive_cycle(1'b0, 1'b0, '0, 1'b0);
      drive_cycle(1'b0, 1'b0, '0, 1'b1);
      drive_cycle(1'b0, 1'b0, '0, 1'b0);
      model_reset();
      check_acc(accumulator_i_o, '0, "I accumulator after clear");
      check_acc(accumulator_q_o, '0, "Q accumulator after clear");
   endtask

   task automatic report_test(input string name, input int errors_before);
      $display("%s: %0d errors", name, error_count - errors_before);
   endtask

   initial begin
      int   base;
      int   assert_failures;
      acc_t base_acc_i;
      acc_t base_acc_q;
      void'($urandom(SEED));
      rst_n_i = 1'b0;
      clear_i = 1'b0;
      sample_valid_i = 1'b0;
      feed_complete_i = 1'b0;
      sample_i = '0;
      doppler_i = '0;
      code_rate_i = '0;
      prn_i = PRN_WIDTH'(1);
      strobe_hist = '0;
      last_hist = '0;
      error_count = 0;
      check_count = 0;
      model_reset();
      repeat (10) @(negedge clk);
      rst_n_i = 1'b1;

      // Idle after reset
      base = error_count;
      repeat (20) begin
         drive_cycle(1'b0, 1'b0, '0, 1'b0);
         check_acc(accumulator_i_o, '0, "I accumulator after reset");
         check_acc(accumulator_q_o, '0, "Q accumulator after reset");
      end
      report_test("test 1 reset state", base);

      // Back-to-back feed, two samples per chip
      base = error_count;
      fill_random(FEED_LEN);
      for (int k = 0; k < FEED_LEN; k++) begin
         base_samples[k] = stim[k];
      end
      run_feed(FEED_LEN, '0, HALF_RATE, 1, 0);
      base_acc_i = model_acc_i;
      base_acc_q = model_acc_q;
      report_test("test 2 continuous feed", base);

      // Doppler at both ends of its range
      base = error_count;
      clear_channel();
      run_feed(FEED_LEN, -16'sd32768, HALF_RATE, 1, 0);
      clear_channel();
      run_feed(FEED_LEN, 16'sd32767, HALF_RATE, 1, 0);
      report_test("test 3 doppler sign", base);

      // Gapped strobes
      base = error_count;
      clear_channel();
      fill_random(GAP_FEED_LEN);
      run_feed(GAP_FEED_LEN, '0, HALF_RATE, 1, 3);
      report_test("test 4 gapped feed", base);

      // Replay of the first feed after clear
      base = error_count;
      clear_channel();
      for (int k = 0; k < FEED_LEN; k++) begin
         stim[k] = base_samples[k];
      end
      run_feed(FEED_LEN, '0, HALF_RATE, 1, 0);
      check_acc(accumulator_i_o, base_acc_i, "I accumulator against test 2");
      check_acc(accumulator_q_o, base_acc_q, "Q accumulator against test 2");
      report_test("test 5 clear and replay", base);

      // Other G2 taps, four samples per chip
      base = error_count;
      clear_channel();
      fill_random(PRN_FEED_LEN);
      run_feed(PRN_FEED_LEN, '0, QUARTER_RATE, 7, 0);
      clear_channel();
      run_feed(PRN_FEED_LEN, '0, QUARTER_RATE, 32, 0);
      report_test("test 6 PRN 7 and 32", base);

      // Bound assertions count their own failures
      assert_failures = u_dut.u_assert.fail_count;
      $display("%0d checks, %0d failed, %0d assertion failures",
               check_count, error_count, assert_failures);
      if (error_count == 0 && assert_failures == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: tb/correlator_assert.sv
`timescale 1ns/1ps

module correlator_assert (
   input logic clk,
   input logic rst_n_i,
   input logic clear_i,
   input logic sample_valid_i,
   input logic feed_complete_i,
   input logic updating_i,
   input logic complete_i
);

   // Number of assertion failures so far
   int fail_count = 0;

   // Updating flag mirrors the strobe four cycles back
   updating_follows_strobe: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      updating_i == $past(sample_valid_i, 4)
   ) else begin
      fail_count++;
      $error("accumulator_updating_o out of step with the sample strobe");
   end

   // Completion is a single-cycle pulse
   complete_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      complete_i |=> !complete_i
   ) else begin
      fail_count++;
      $error("accumulation_complete_o held for more than one cycle");
   end

   // No clear while a sample is in flight
   clear_after_strobe: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      clear_i |-> !sample_valid_i && !$past(sample_valid_i, 1) && !$past(sample_valid_i, 2)
         && !$past(sample_valid_i, 3) && !$past(sample_valid_i, 4)
         && !$past(sample_valid_i, 5)
   ) else begin
      fail_count++;
      $error("clear_i given within 5 cycles of a sample strobe");
   end

   // Completion trails the feed-complete strobe by five cycles
   complete_follows_last: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      complete_i == $past(sample_valid_i && feed_complete_i, 5)
   ) else begin
      fail_count++;
      $error("accumulation_complete_o out of step with the last strobe");
   end

endmodule

// File: verilog/correlator_channel.sv
`timescale 1ns/1ps

module correlator_channel
   import gps_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic                      clear_i,
   input  logic                      sample_valid_i,
   input  logic                      feed_complete_i,
   input  sample_t                   sample_i,
   input  doppler_t                  doppler_i,
   input  logic [CODE_ACC_WIDTH-1:0] code_rate_i,
   input  logic [PRN_WIDTH-1:0]      prn_i,
   output acc_t                      accumulator_i_o,
   output acc_t                      accumulator_q_o,
   output logic                      accumulator_updating_o,
   output logic                      accumulation_complete_o
);

   logic code_msb;
   logic code_msb_q;
   logic strobe_q;
   logic code_step;
   logic ca_chip;

   // Code NCO, one add per strobe
   carrier_dds #(.INDEX_WIDTH(1)) u_code_nco (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .clear_i  (clear_i),
      .enable_i (sample_valid_i),
      .inc_i    (code_rate_i),
      .index_o  (code_msb)
   );

   // Phase MSB seen at each strobe, before its add
   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         strobe_q <= 1'b0;
         code_msb_q <= 1'b0;
      end else begin
         strobe_q <= sample_valid_i;
         if (sample_valid_i) begin
            code_msb_q <= code_msb;
         end
      end
   end

   // Carry shows as the MSB falling across the add
   // Holds for code rates up to half the sample rate
   // Step lands one cycle after the strobe
   assign code_step = strobe_q & code_msb_q & ~code_msb;

   ca_code_gen u_code_gen (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .clear_i (clear_i),
      .step_i  (code_step),
      .prn_i   (prn_i),
      .chip_o  (ca_chip)
   );

   subchannel u_subchannel (
      .clk                     (clk),
      .rst_n_i                 (rst_n_i),
      .clear_i                 (clear_i),
      .sample_valid_i          (sample_valid_i),
      .feed_complete_i         (feed_complete_i),
      .sample_i                (sample_i),
      .doppler_i               (doppler_i),
      .ca_bit_i                (ca_chip),
      .acc_i_o                 (accumulator_i_o),
      .acc_q_o                 (accumulator_q_o),
      .accumulator_updating_o  (accumulator_updating_o),
      .accumulation_complete_o (accumulation_complete_o)
   );

endmodule

// File: verilog/ca_code_gen.sv
`timescale 1ns/1ps

module ca_code_gen
   import gps_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 clear_i,
   input  logic                 step_i,
   input  logic [PRN_WIDTH-1:0] prn_i,
   output logic                 chip_o
);

   // Stage 1 takes the feedback, stage 10 is the output end
   logic [10:1]          g1_q;
   logic [10:1]          g2_q;
   logic                 g1_fb;
   logic                 g2_fb;
   logic [PRN_WIDTH-1:0] prn_idx;
   logic [3:0]           tap_a;
   logic [3:0]           tap_b;

   // G1 polynomial 1 + x^3 + x^10
   assign g1_fb = g1_q[3] ^ g1_q[10];

   // G2 polynomial 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
   assign g2_fb = g2_q[2] ^ g2_q[3] ^ g2_q[6] ^ g2_q[8] ^ g2_q[9] ^ g2_q[10];

   // PRN 32 arrives as 0 on the 5-bit port and wraps to entry 31
   assign prn_idx = prn_i - 1'b1;
   assign tap_a = G2_TAPS[prn_idx][0];
   assign tap_b = G2_TAPS[prn_idx][1];

   // Both registers restart at all ones
   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         g1_q <= '1;
         g2_q <= '1;
      end else if (step_i) begin
         g1_q <= {g1_q[9:1], g1_fb};
         g2_q <= {g2_q[9:1], g2_fb};
      end
   end

   // G2 delayed by phase-select XOR, then mod-2 with G1
   assign chip_o = g1_q[10] ^ g2_q[tap_a] ^ g2_q[tap_b];

endmodule

// File: verilog/subchannel.sv
`timescale 1ns/1ps

module subchannel
   import gps_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n_i,
   input  logic     clear_i,
   input  logic     sample_valid_i,
   input  logic     feed_complete_i,
   input  sample_t  sample_i,
   input  doppler_t doppler_i,
   input  logic     ca_bit_i,
   output acc_t     acc_i_o,
   output acc_t     acc_q_o,
   output logic     accumulator_updating_o,
   output logic     accumulation_complete_o
);

   logic                         valid_mix;
   sample_t                      sample_mix;
   logic                         chip_mix;
   logic [CARRIER_ACC_WIDTH-1:0] carrier_inc;
   carrier_index_t               carrier_index;
   carrier_t                     carrier_cos;
   carrier_t                     carrier_sin;
   mixed_t                       mixed_i;
   mixed_t                       mixed_q;

   baseband_if bb ();

   // Strobe and sample meet the carrier index CA_PIPE_DELAY cycles later
   delay_line #(.T(logic), .DELAY(CA_PIPE_DELAY)) u_valid_delay (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (sample_valid_i),
      .out_o   (valid_mix)
   );

   delay_line #(.T(sample_t), .DELAY(CA_PIPE_DELAY)) u_sample_delay (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (sample_i),
      .out_o   (sample_mix)
   );

   // Chip is taken one cycle after the strobe
   // Code generator steps for earlier strobes have landed by then
   delay_line #(.T(logic), .DELAY(CA_PIPE_DELAY - 1)) u_chip_delay (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (ca_bit_i),
      .out_o   (chip_mix)
   );

   // IF plus sign-extended Doppler
   assign carrier_inc = F_IF_INC
                      + {{(CARRIER_ACC_WIDTH-DOPPLER_WIDTH){doppler_i[DOPPLER_WIDTH-1]}}, doppler_i};

   // Steps once per delayed strobe
   // Index in the strobe cycle is the phase before the step
   carrier_dds u_carrier_dds (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .clear_i  (clear_i),
      .enable_i (valid_mix),
      .inc_i    (carrier_inc),
      .index_o  (carrier_index)
   );

   carrier_lut u_carrier_lut (
      .index_i (carrier_index),
      .cos_o   (carrier_cos),
      .sin_o   (carrier_sin)
   );

   // Carrier wipe-off
   assign mixed_i = mixed_t'(sample_mix) * mixed_t'(carrier_cos);
   assign mixed_q = mixed_t'(sample_mix) * mixed_t'(carrier_sin);

   assign bb.clear = clear_i;

   // Register products, chip and strobe into the track inputs
   delay_line #(.T(logic), .DELAY(1)) u_track_valid (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (valid_mix),
      .out_o   (bb.valid)
   );

   delay_line #(.T(logic), .DELAY(1)) u_track_chip (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (chip_mix),
      .out_o   (bb.ca_bit)
   );

   delay_line #(.T(mixed_t), .DELAY(1)) u_track_mixed_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (mixed_i),
      .out_o   (bb.mixed_i)
   );

   delay_line #(.T(mixed_t), .DELAY(1)) u_track_mixed_q (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (mixed_q),
      .out_o   (bb.mixed_q)
   );

   // High while the track wipe-off stage holds a sample
   delay_line #(.T(logic), .DELAY(1)) u_updating_delay (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (bb.valid),
      .out_o   (accumulator_updating_o)
   );

   // Pipe depth plus input register plus two track stages
   delay_line #(.T(logic), .DELAY(CA_PIPE_DELAY + 3)) u_complete_delay (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .in_i    (sample_valid_i && feed_complete_i),
      .out_o   (accumulation_complete_o)
   );

   track_accumulator u_track_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bb         (bb),
      .select_q_i (1'b0),
      .acc_o      (acc_i_o)
   );

   track_accumulator u_track_q (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .bb         (bb),
      .select_q_i (1'b1),
      .acc_o      (acc_q_o)
   );

endmodule

// File: verilog/track_accumulator.sv
`timescale 1ns/1ps

module track_accumulator
   import gps_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n_i,
   baseband_if.sink        bb,
   // Tied at the instance, 0 for I and 1 for Q
   input  logic            select_q_i,
   output acc_t            acc_o
);

   mixed_t product;
   mixed_t wiped_q;
   logic   wiped_valid_q;

   assign product = select_q_i ? bb.mixed_q : bb.mixed_i;

   // Stage one, code wipe-off
   // Chip 1 maps to -1
   always_ff @(posedge clk) begin
      if (!rst_n_i || bb.clear) begin
         wiped_q <= '0;
         wiped_valid_q <= 1'b0;
      end else begin
         wiped_valid_q <= bb.valid;
         if (bb.valid) begin
            wiped_q <= bb.ca_bit ? -product : product;
         end
      end
   end

   // Stage two, wrapping sum of sign-extended products
   always_ff @(posedge clk) begin
      if (!rst_n_i || bb.clear) begin
         acc_o <= '0;
      end else if (wiped_valid_q) begin
         acc_o <= acc_o + acc_t'(wiped_q);
      end
   end

endmodule

// File: verilog/carrier_lut.sv
`timescale 1ns/1ps

module carrier_lut
   import gps_pkg::*;
(
   input  carrier_index_t index_i,
   output carrier_t       cos_o,
   output carrier_t       sin_o
);

   `include "carrier_table.svh"

   logic [1:0] quadrant;
   logic [2:0] offset;
   logic [2:0] mirror_idx;
   carrier_t   direct_mag;
   carrier_t   mirror_mag;
   carrier_t   sin_raw;

   // Top two bits pick the quadrant, the rest the phase within it
   assign quadrant = index_i[CARRIER_INDEX_WIDTH-1 -: 2];
   assign offset = index_i[CARRIER_INDEX_WIDTH-3:0];

   // Mirror runs from the other end of the quarter wave
   assign mirror_idx = 3'd0 - offset;
   assign direct_mag = carrier_t'({1'b0, COS_QUARTER[offset]});
   // Offset 0 mirrors onto the zero crossing
   assign mirror_mag = (offset == 3'd0) ? '0 : carrier_t'({1'b0, COS_QUARTER[mirror_idx]});

   always_comb begin
      case (quadrant)
         2'd0: begin
            cos_o = direct_mag;
            sin_raw = mirror_mag;
         end
         2'd1: begin
            cos_o = -mirror_mag;
            sin_raw = direct_mag;
         end
         2'd2: begin
            cos_o = -direct_mag;
            sin_raw = -mirror_mag;
         end
         default: begin
            cos_o = mirror_mag;
            sin_raw = -direct_mag;
         end
      endcase
   end

   // Quadrature carrier is inverted for high-side mixing
   assign sin_o = MIXING_SIGN ? -sin_raw : sin_raw;

endmodule

// File: verilog/carrier_dds.sv
`timescale 1ns/1ps

module carrier_dds
   import gps_pkg::*;
#(
   // Top phase bits brought out
   parameter int unsigned INDEX_WIDTH = CARRIER_INDEX_WIDTH
) (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         clear_i,
   input  logic                         enable_i,
   input  logic [CARRIER_ACC_WIDTH-1:0] inc_i,
   output logic [INDEX_WIDTH-1:0]       index_o
);

   logic [CARRIER_ACC_WIDTH-1:0] phase_q;

   // Phase wraps modulo 2^CARRIER_ACC_WIDTH
   always_ff @(posedge clk) begin
      if (!rst_n_i || clear_i) begin
         phase_q <= '0;
      end else if (enable_i) begin
         phase_q <= phase_q + inc_i;
      end
   end

   // Taken straight from the phase register
   // During an enable cycle this is still the phase before the add
   assign index_o = phase_q[CARRIER_ACC_WIDTH-1 -: INDEX_WIDTH];

endmodule

// File: verilog/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
   parameter type T = logic,
   parameter int unsigned DELAY = 1
) (
   input  logic clk,
   input  logic rst_n_i,
   input  T     in_i,
   output T     out_o
);

   // Stage 0 is nearest the input
   T pipe_q [DELAY];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < DELAY; i++) begin
            pipe_q[i] <= '0;
         end
      end else begin
         pipe_q[0] <= in_i;
         for (int i = 1; i < DELAY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign out_o = pipe_q[DELAY-1];

endmodule

// File: verilog/baseband_if.sv
`timescale 1ns/1ps

interface baseband_if import gps_pkg::*; ();

   // Zeroes both track stages
   logic   clear;
   // One-cycle strobe for the fields below
   logic   valid;
   logic   ca_bit;
   mixed_t mixed_i;
   mixed_t mixed_q;

   modport source (output clear, output valid, output ca_bit, output mixed_i, output mixed_q);

   modport sink (input clear, input valid, input ca_bit, input mixed_i, input mixed_q);

endinterface

// File: verilog/gps_pkg.sv
package gps_pkg;

   // Front-end sample, two's complement
   localparam int unsigned INPUT_WIDTH = 3;

   // Carrier NCO and lookup
   localparam int unsigned CARRIER_ACC_WIDTH = 32;
   // 32 phases per carrier cycle
   localparam int unsigned CARRIER_INDEX_WIDTH = 5;
   localparam int unsigned CARRIER_LUT_WIDTH = 4;

   // Sample times carrier
   localparam int unsigned MIXED_WIDTH = INPUT_WIDTH + CARRIER_LUT_WIDTH;

   // Track accumulators wrap at this width
   localparam int unsigned ACC_WIDTH = 24;

   // Doppler increment, sign-extended up to CARRIER_ACC_WIDTH
   localparam int unsigned DOPPLER_WIDTH = 16;

   // IF of 4.1304 MHz at 16.368 MHz sampling
   localparam logic [CARRIER_ACC_WIDTH-1:0] F_IF_INC = 32'd1083817923;

   // High-side mixing inverts the quadrature carrier
   localparam bit MIXING_SIGN = 1'b1;

   // Code NCO, one chip per carry
   localparam int unsigned CODE_ACC_WIDTH = 32;
   localparam int unsigned PRN_WIDTH = 5;

   // Sample delay while the carrier index and chip settle
   localparam int unsigned CA_PIPE_DELAY = 2;

   // G2 phase-select taps, entry 0 is PRN 1 and entry 31 is PRN 32
   localparam logic [3:0] G2_TAPS [0:31][0:1] = '{
      '{4'd2, 4'd6}, '{4'd3, 4'd7}, '{4'd4, 4'd8}, '{4'd5, 4'd9},
      '{4'd1, 4'd9}, '{4'd2, 4'd10}, '{4'd1, 4'd8}, '{4'd2, 4'd9},
      '{4'd3, 4'd10}, '{4'd2, 4'd3}, '{4'd3, 4'd4}, '{4'd5, 4'd6},
      '{4'd6, 4'd7}, '{4'd7, 4'd8}, '{4'd8, 4'd9}, '{4'd9, 4'd10},
      '{4'd1, 4'd4}, '{4'd2, 4'd5}, '{4'd3, 4'd6}, '{4'd4, 4'd7},
      '{4'd5, 4'd8}, '{4'd6, 4'd9}, '{4'd1, 4'd3}, '{4'd4, 4'd6},
      '{4'd5, 4'd7}, '{4'd6, 4'd8}, '{4'd7, 4'd9}, '{4'd8, 4'd10},
      '{4'd1, 4'd6}, '{4'd2, 4'd7}, '{4'd3, 4'd8}, '{4'd4, 4'd9}
   };

   // Payload types
   typedef logic signed [INPUT_WIDTH-1:0] sample_t;
   typedef logic signed [CARRIER_LUT_WIDTH-1:0] carrier_t;
   typedef logic signed [MIXED_WIDTH-1:0] mixed_t;
   typedef logic signed [ACC_WIDTH-1:0] acc_t;
   typedef logic signed [DOPPLER_WIDTH-1:0] doppler_t;
   typedef logic [CARRIER_INDEX_WIDTH-1:0] carrier_index_t;

endpackage

// File: include/carrier_table.svh
`ifndef CARRIER_TABLE_SVH
`define CARRIER_TABLE_SVH

// Quarter-wave cosine magnitudes
// Entry k is round(7 * cos(2*pi*k/32)) for k = 0..7
// Remaining quadrants come from symmetry in the lookup
// Value at k = 8 is zero and is not stored
localparam logic [CARRIER_LUT_WIDTH-2:0] COS_QUARTER [0:7] = '{
   3'd7,
   3'd7,
   3'd6,
   3'd6,
   3'd5,
   3'd4,
   3'd3,
   3'd1
};

`endif
